//--- hdl/kvs_tx_pkg.sv
// --------------------------------------
// kvs transmit package
// shared word, record and state types for the transmit path
// --------------------------------------
package kvs_tx_pkg;

   // bytes carried by one 64-bit data word
   parameter int BYTES_PER_WORD = 8;

   typedef logic [15:0] port_t;

   // response word from the store core
   typedef struct packed {
      logic        last;
      logic [63:0] meta;
      logic [63:0] data;
   } kvs_word_t;

   // network data word
   typedef struct packed {
      logic        last;
      logic [63:0] data;
   } tx_word_t;

   // transmit metadata record, length in the upper half
   typedef struct packed {
      logic [15:0] length;
      logic [15:0] session;
   } tx_meta_t;

   typedef enum logic [1:0] {
      first_word,
      in_frame,
      meta_pending
   } framer_state_e;

   typedef enum logic {
      offer,
      done
   } opener_state_e;

endpackage

//--- hdl/kvs_tx_top.sv
// --------------------------------------
// kvs transmit top
// listen port requests plus framed response data and metadata
// --------------------------------------
`timescale 1ns/1ps

module kvs_tx_top #(
   parameter int FIRST_PORT     = 2880,
   parameter int PORT_COUNT     = 8,
   parameter int DATA_ADDR_BITS = 8,
   parameter int META_ADDR_BITS = 4
) (
   input  logic                  aclk,
   input  logic                  aresetn,
   output logic                  listen_valid,
   input  logic                  listen_ready,
   output kvs_tx_pkg::port_t     listen_port,
   input  logic                  resp_valid,
   output logic                  resp_ready,
   input  kvs_tx_pkg::kvs_word_t resp_word,
   output logic                  tx_data_valid,
   input  logic                  tx_data_ready,
   output logic [63:0]           tx_data,
   output logic                  tx_last,
   output logic                  tx_meta_valid,
   input  logic                  tx_meta_ready,
   output kvs_tx_pkg::tx_meta_t  tx_meta
);

   logic                 word_valid;
   logic                 word_ready;
   kvs_tx_pkg::tx_word_t word;
   kvs_tx_pkg::tx_word_t tx_word;
   logic                 meta_valid;
   logic                 meta_ready;
   kvs_tx_pkg::tx_meta_t meta;

   listen_port_opener #(
      .FIRST_PORT (FIRST_PORT),
      .PORT_COUNT (PORT_COUNT)
   ) u_opener (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .listen_valid (listen_valid),
      .listen_ready (listen_ready),
      .listen_port  (listen_port)
   );

   resp_framer u_framer (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .resp_valid (resp_valid),
      .resp_ready (resp_ready),
      .resp_word  (resp_word),
      .word_valid (word_valid),
      .word_ready (word_ready),
      .word       (word),
      .meta_valid (meta_valid),
      .meta_ready (meta_ready),
      .meta       (meta)
   );

   // --------------------------------------
   // output buffers
   // --------------------------------------
   stream_fifo #(
      .WIDTH     ($bits(kvs_tx_pkg::tx_word_t)),
      .ADDR_BITS (DATA_ADDR_BITS)
   ) u_data_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (word_valid),
      .in_ready  (word_ready),
      .in_data   (word),
      .out_valid (tx_data_valid),
      .out_ready (tx_data_ready),
      .out_data  (tx_word)
   );

   stream_fifo #(
      .WIDTH     ($bits(kvs_tx_pkg::tx_meta_t)),
      .ADDR_BITS (META_ADDR_BITS)
   ) u_meta_fifo (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_valid  (meta_valid),
      .in_ready  (meta_ready),
      .in_data   (meta),
      .out_valid (tx_meta_valid),
      .out_ready (tx_meta_ready),
      .out_data  (tx_meta)
   );

   assign tx_data = tx_word.data;
   assign tx_last = tx_word.last;

endmodule

//--- hdl/listen_port_opener.sv
// --------------------------------------
// listen port opener
// requests a range of server ports once after reset
// --------------------------------------
`timescale 1ns/1ps

module listen_port_opener #(
   parameter int FIRST_PORT = 2880,
   parameter int PORT_COUNT = 8
) (
   input  logic              aclk,
   input  logic              aresetn,
   output logic              listen_valid,
   input  logic              listen_ready,
   output kvs_tx_pkg::port_t listen_port
);

   localparam kvs_tx_pkg::port_t LAST_PORT =
      kvs_tx_pkg::port_t'(FIRST_PORT + PORT_COUNT - 1);

   kvs_tx_pkg::opener_state_e state;

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state        <= kvs_tx_pkg::offer;
         listen_valid <= 1'b0;
         listen_port  <= kvs_tx_pkg::port_t'(FIRST_PORT);
      end else begin
         case (state)
            kvs_tx_pkg::offer: begin
               if (!listen_valid) begin
                  // first cycle out of reset
                  listen_valid <= 1'b1;
               end else if (listen_ready) begin
                  if (listen_port == LAST_PORT) begin
                     listen_valid <= 1'b0;
                     state        <= kvs_tx_pkg::done;
                  end else begin
                     listen_port <= listen_port + 1'b1;
                  end
               end
            end
            default: begin
               // idle until the next reset
               listen_valid <= 1'b0;
            end
         endcase
      end
   end

   // pending request keeps its port
   assert property (@(posedge aclk) disable iff (!aresetn)
      listen_valid && !listen_ready |=> listen_valid && $stable(listen_port));

endmodule

//--- hdl/resp_framer.sv
// --------------------------------------
// response framer
// forwards response data and builds one metadata record per frame
// --------------------------------------
`timescale 1ns/1ps

module resp_framer (
   input  logic                  aclk,
   input  logic                  aresetn,
   input  logic                  resp_valid,
   output logic                  resp_ready,
   input  kvs_tx_pkg::kvs_word_t resp_word,
   output logic                  word_valid,
   input  logic                  word_ready,
   output kvs_tx_pkg::tx_word_t  word,
   output logic                  meta_valid,
   input  logic                  meta_ready,
   output kvs_tx_pkg::tx_meta_t  meta
);

   localparam logic [15:0] LEN_STEP = 16'(kvs_tx_pkg::BYTES_PER_WORD);

   kvs_tx_pkg::framer_state_e state;
   logic [15:0]               session_q;
   logic [15:0]               len_q;
   logic                      pending;
   logic                      accept;

   assign pending = (state == kvs_tx_pkg::meta_pending);

   // --------------------------------------
   // data path, straight into the data FIFO
   // --------------------------------------
   // input stalls while the previous record has not left
   assign resp_ready = word_ready && !pending;
   assign word_valid = resp_valid && !pending;
   assign word.last  = resp_word.last;
   assign word.data  = resp_word.data;

   assign accept = resp_valid && resp_ready;

   assign meta_valid   = pending;
   assign meta.length  = len_q;
   assign meta.session = session_q;

   // --------------------------------------
   // frame tracking
   // --------------------------------------
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         state <= kvs_tx_pkg::first_word;
      end else begin
         case (state)
            kvs_tx_pkg::first_word: begin
               if (accept && resp_word.last) begin
                  state <= kvs_tx_pkg::meta_pending;
               end else if (accept) begin
                  state <= kvs_tx_pkg::in_frame;
               end
            end
            kvs_tx_pkg::in_frame: begin
               if (accept && resp_word.last) begin
                  state <= kvs_tx_pkg::meta_pending;
               end
            end
            default: begin
               if (meta_ready) begin
                  state <= kvs_tx_pkg::first_word;
               end
            end
         endcase
      end
   end

   // session and length of the frame being collected
   always_ff @(posedge aclk) begin
      if (accept) begin
         if (state == kvs_tx_pkg::first_word) begin
            session_q <= resp_word.meta[15:0];
            len_q     <= LEN_STEP;
         end else begin
            len_q <= len_q + LEN_STEP;
         end
      end
   end

   // a waiting record holds its length and session until taken
   assert property (@(posedge aclk) disable iff (!aresetn)
      meta_valid && !meta_ready |=> meta_valid && $stable(meta));

endmodule

//--- hdl/stream_fifo.sv
// --------------------------------------
// stream FIFO
// first-word-fall-through buffer with valid/ready on both sides
// --------------------------------------
`timescale 1ns/1ps

module stream_fifo #(
   parameter int WIDTH     = 32,
   parameter int ADDR_BITS = 4
) (
   input  logic             aclk,
   input  logic             aresetn,
   input  logic             in_valid,
   output logic             in_ready,
   input  logic [WIDTH-1:0] in_data,
   output logic             out_valid,
   input  logic             out_ready,
   output logic [WIDTH-1:0] out_data
);

   localparam int DEPTH = 1 << ADDR_BITS;

   logic [WIDTH-1:0]     mem [DEPTH];
   logic [ADDR_BITS-1:0] wr_ptr;
   logic [ADDR_BITS-1:0] rd_ptr;
   logic [ADDR_BITS:0]   count;
   logic                 push;
   logic                 pop;

   assign in_ready  = (count != (ADDR_BITS + 1)'(DEPTH));
   assign out_valid = (count != '0);
   // head entry is read straight from the array
   assign out_data  = mem[rd_ptr];

   assign push = in_valid && in_ready;
   assign pop  = out_valid && out_ready;

   always_ff @(posedge aclk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // --------------------------------------
   // pointers and occupancy
   // --------------------------------------
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // pointers and occupancy agree and never pass full
   assert property (@(posedge aclk) disable iff (!aresetn)
      count <= (ADDR_BITS + 1)'(DEPTH) && wr_ptr - rd_ptr == count[ADDR_BITS-1:0]);

   // head word holds while the consumer stalls
   assert property (@(posedge aclk) disable iff (!aresetn)
      out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

//--- run.sh
#!/bin/sh
# build the kvs transmit testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_kvs_tx \
   -o sim_kvs_tx &&
./obj_dir/sim_kvs_tx | tee /dev/stderr | grep -x "all tests passed" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation did not pass"; exit 1; }

//--- test/tb_kvs_tx.sv
// ----------------------------------------
// kvs transmit testbench
// listen port requests and table driven response frames
// ----------------------------------------
`timescale 1ns/1ps

module tb_kvs_tx;

   localparam int FIRST_PORT   = 2880;
   localparam int PORT_COUNT   = 8;
   localparam int NUM_FRAMES   = 27;
   localparam int STALL_FRAMES = 17;
   localparam int WAIT_LIMIT   = 2000;

   // one table row: session, word count, expected length, meta stall
   typedef struct packed {
      logic [15:0] session;
      logic [2:0]  words;
      logic [15:0] length;
      logic        stall;
   } frame_t;

   logic                  aclk;
   logic                  aresetn;
   logic                  listen_valid;
   logic                  listen_ready;
   kvs_tx_pkg::port_t     listen_port;
   logic                  resp_valid;
   logic                  resp_ready;
   kvs_tx_pkg::kvs_word_t resp_word;
   logic                  tx_data_valid;
   logic                  tx_data_ready;
   logic [63:0]           tx_data;
   logic                  tx_last;
   logic                  tx_meta_valid;
   logic                  tx_meta_ready;
   kvs_tx_pkg::tx_meta_t  tx_meta;

   frame_t      frames [NUM_FRAMES];
   logic [64:0] exp_data [$];
   logic [31:0] exp_meta [$];
   logic [64:0] data_head;
   logic [31:0] meta_head;
   logic [31:0] rng = 32'h25f3_6e2c;
   int          errors = 0;
   int          checks = 0;
   int          ports_seen = 0;
   int          data_seen = 0;
   int          meta_seen = 0;

   kvs_tx_top #(
      .FIRST_PORT     (FIRST_PORT),
      .PORT_COUNT     (PORT_COUNT),
      .DATA_ADDR_BITS (8),
      .META_ADDR_BITS (4)
   ) u_dut (
      .aclk          (aclk),
      .aresetn       (aresetn),
      .listen_valid  (listen_valid),
      .listen_ready  (listen_ready),
      .listen_port   (listen_port),
      .resp_valid    (resp_valid),
      .resp_ready    (resp_ready),
      .resp_word     (resp_word),
      .tx_data_valid (tx_data_valid),
      .tx_data_ready (tx_data_ready),
      .tx_data       (tx_data),
      .tx_last       (tx_last),
      .tx_meta_valid (tx_meta_valid),
      .tx_meta_ready (tx_meta_ready),
      .tx_meta       (tx_meta)
   );

   initial begin
      aclk = 1'b0;
      forever #50 aclk = ~aclk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   // data word rule from frame and word index
   function automatic logic [63:0] make_data(input int f, input int w);
      return {16'hda7a, 16'(f), 16'(w), 16'(f * 31 + w)};
   endfunction

   // only the first word carries the real session in the low bits
   function automatic kvs_tx_pkg::kvs_word_t make_word(input int f, input int w);
      kvs_tx_pkg::kvs_word_t k;
      k.last = (w == int'(frames[f].words) - 1);
      k.data = make_data(f, w);
      k.meta = {frames[f].session, 16'(w), 16'h0,
                (w == 0) ? frames[f].session : ~frames[f].session};
      return k;
   endfunction

   task automatic fill_table();
      frames[0] = '{16'h1234, 3'd1, 16'd8, 1'b0};
      frames[1] = '{16'h0042, 3'd3, 16'd24, 1'b0};
      frames[2] = '{16'hbeef, 3'd6, 16'd48, 1'b0};
      frames[3] = '{16'h0007, 3'd2, 16'd16, 1'b0};
      frames[4] = '{16'h1001, 3'd4, 16'd32, 1'b0};
      frames[5] = '{16'ha5a5, 3'd5, 16'd40, 1'b0};
      frames[6] = '{16'h0abc, 3'd1, 16'd8, 1'b0};
      frames[7] = '{16'h7777, 3'd6, 16'd48, 1'b0};
      // a run of frames whose records are held back
      for (int i = 0; i < STALL_FRAMES; i++) begin
         frames[8 + i].session = 16'h5100 + 16'(i);
         frames[8 + i].words   = 3'(1 + i % 4);
         frames[8 + i].length  = 16'(kvs_tx_pkg::BYTES_PER_WORD * (1 + i % 4));
         frames[8 + i].stall   = 1'b1;
      end
      frames[25] = '{16'hc0de, 3'd2, 16'd16, 1'b0};
      frames[26] = '{16'h0fff, 3'd3, 16'd24, 1'b0};
   endtask

   task automatic build_expected();
      for (int f = 0; f < NUM_FRAMES; f++) begin
         for (int w = 0; w < int'(frames[f].words); w++) begin
            exp_data.push_back({w == int'(frames[f].words) - 1, make_data(f, w)});
         end
         exp_meta.push_back({frames[f].length, frames[f].session});
      end
   endtask

   // called 1 ns after a rising edge, returns at the same point
   task automatic send_word(input kvs_tx_pkg::kvs_word_t w);
      int waited;
      waited     = 0;
      resp_valid = 1'b1;
      resp_word  = w;
      @(negedge aclk);
      while (!resp_ready && waited < WAIT_LIMIT) begin
         waited++;
         @(negedge aclk);
      end
      if (!resp_ready) begin
         errors++;
         $display("timeout while a response word waited to be accepted");
      end
      @(posedge aclk);
      #1;
      resp_valid = 1'b0;
   endtask

   // offer the next word while the record buffer is full, then release it
   task automatic hold_while_stalled(input kvs_tx_pkg::kvs_word_t w);
      int waited;
      waited     = 0;
      resp_valid = 1'b1;
      resp_word  = w;
      @(negedge aclk);
      while (resp_ready && waited < WAIT_LIMIT) begin
         waited++;
         @(negedge aclk);
      end
      if (resp_ready) begin
         errors++;
         $display("timeout while resp_ready stayed high with records held back");
      end
      repeat (8) begin
         @(negedge aclk);
         check_value("resp_ready", 64'(resp_ready), 64'd0);
      end
      @(posedge aclk);
      #1;
      tx_meta_ready = 1'b1;
   endtask

   // ----------------------------------------
   // ready drivers and monitors
   // ----------------------------------------
   always @(posedge aclk) begin
      #1;
      rng           = xorshift32(rng);
      listen_ready  = rng[3];
      tx_data_ready = rng[1] | rng[2];
   end

   always @(negedge aclk) begin
      if (aresetn && listen_valid && listen_ready) begin
         if (ports_seen >= PORT_COUNT) begin
            errors++;
            $display("listen request seen after the last port");
         end else begin
            check_value("listen_port", 64'(listen_port), 64'(FIRST_PORT + ports_seen));
         end
         ports_seen++;
      end
   end

   always @(negedge aclk) begin
      if (aresetn && tx_data_valid && tx_data_ready) begin
         if (exp_data.size() == 0) begin
            errors++;
            $display("unexpected data word %h on the transmit stream", tx_data);
         end else begin
            data_head = exp_data.pop_front();
            check_value("tx_data", tx_data, data_head[63:0]);
            check_value("tx_last", 64'(tx_last), 64'(data_head[64]));
         end
         data_seen++;
      end
   end

   always @(negedge aclk) begin
      if (aresetn && tx_meta_valid && tx_meta_ready) begin
         if (exp_meta.size() == 0) begin
            errors++;
            $display("unexpected metadata record %h", tx_meta);
         end else begin
            meta_head = exp_meta.pop_front();
            check_value("tx_meta.length", 64'(tx_meta.length), 64'(meta_head[31:16]));
            check_value("tx_meta.session", 64'(tx_meta.session), 64'(meta_head[15:0]));
         end
         meta_seen++;
      end
   end

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      int waited;
      aresetn       = 1'b0;
      listen_ready  = 1'b0;
      resp_valid    = 1'b0;
      resp_word     = '0;
      tx_data_ready = 1'b0;
      tx_meta_ready = 1'b1;
      fill_table();
      build_expected();
      repeat (5) @(posedge aclk);
      #1;
      aresetn = 1'b1;
      check_value("tx_data_valid", 64'(tx_data_valid), 64'd0);
      check_value("tx_meta_valid", 64'(tx_meta_valid), 64'd0);
      check_value("listen_valid", 64'(listen_valid), 64'd0);
      @(posedge aclk);
      @(negedge aclk);
      check_value("listen_valid", 64'(listen_valid), 64'd1);

      // all listen ports, then a quiet listen stream
      waited = 0;
      while (ports_seen < PORT_COUNT && waited < WAIT_LIMIT) begin
         waited++;
         @(negedge aclk);
      end
      if (ports_seen < PORT_COUNT) begin
         errors++;
         $display("timeout with only %0d listen ports delivered", ports_seen);
      end
      repeat (50) begin
         @(negedge aclk);
         check_value("listen_valid", 64'(listen_valid), 64'd0);
      end

      @(posedge aclk);
      #1;
      for (int f = 0; f < NUM_FRAMES; f++) begin
         if (f > 0 && frames[f - 1].stall && !frames[f].stall) begin
            hold_while_stalled(make_word(f, 0));
         end
         if (f > 0 && !frames[f - 1].stall && frames[f].stall) begin
            // earlier records leave first so the held run fills the record buffer
            waited = 0;
            while (meta_seen < f && waited < WAIT_LIMIT) begin
               waited++;
               @(negedge aclk);
            end
            if (meta_seen < f) begin
               errors++;
               $display("timeout while earlier records drained");
            end
            @(posedge aclk);
            #1;
         end
         tx_meta_ready = !frames[f].stall;
         for (int w = 0; w < int'(frames[f].words); w++) begin
            send_word(make_word(f, w));
         end
      end
      tx_meta_ready = 1'b1;

      waited = 0;
      while ((exp_data.size() != 0 || exp_meta.size() != 0) && waited < WAIT_LIMIT) begin
         waited++;
         @(negedge aclk);
      end
      if (exp_data.size() != 0 || exp_meta.size() != 0) begin
         errors++;
         $display("timeout with %0d data words and %0d records still missing",
                  exp_data.size(), exp_meta.size());
      end
      @(negedge aclk);
      check_value("tx_data_valid", 64'(tx_data_valid), 64'd0);
      check_value("tx_meta_valid", 64'(tx_meta_valid), 64'd0);

      $display("errors %0d, checks %0d, ports %0d, data words %0d, records %0d",
               errors, checks, ports_seen, data_seen, meta_seen);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
hdl/kvs_tx_pkg.sv
hdl/stream_fifo.sv
hdl/listen_port_opener.sv
hdl/resp_framer.sv
hdl/kvs_tx_top.sv
test/tb_kvs_tx.sv
